// File: build.f
+incdir+src
src/mem_pkg.sv
src/bus_arbiter_fsm.sv
src/bus_route.sv
src/latency_timer.sv
src/line_memory.sv
src/mem_subsystem_top.sv
testbench/mem_subsystem_tb.sv

// File: run.sh
#!/bin/sh
# compile the testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module mem_subsystem_tb -o sim_mem_subsystem
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_mem_subsystem > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

grep -q "RESULT: PASS" sim.log
if [ $? -ne 0 ]; then
    echo "pass line not found in sim.log"
    exit 1
fi

echo "simulation passed"
exit 0

// File: src/bus_arbiter_fsm.sv
module bus_arbiter_fsm
    import mem_pkg::*;
(
    input  logic       clock,
    input  logic       rst,
    input  logic       req1_active,
    input  logic       req2_active,
    input  logic       bus_ready,
    output arb_state_t grant
);

    arb_state_t state;
    arb_state_t next_state;
    arb_state_t pick;                                       // choice made from idle

    assign grant = state;

    // cache 1 wins whenever it requests, so cache 2 is
    // never picked while cache 1 still holds its strobe
    always_comb begin
        if (req1_active) begin
            pick = ARB_CACHE1;
        end else if (req2_active) begin
            pick = ARB_CACHE2;
        end else begin
            pick = ARB_IDLE;
        end
    end

    // the owner keeps the bus until the memory answers.
    // an owner that already finished and has no new request
    // lets the other cache in on the following edge
    always_comb begin
        next_state = ARB_IDLE;
        case (state)
            ARB_IDLE: begin
                next_state = pick;
            end
            ARB_CACHE1: begin
                if (!bus_ready && req1_active) begin
                    next_state = ARB_CACHE1;                // access in flight
                end else begin
                    next_state = pick;
                end
            end
            ARB_CACHE2: begin
                if (!bus_ready && req2_active) begin
                    next_state = ARB_CACHE2;                // access in flight
                end else begin
                    next_state = pick;
                end
            end
            default: begin
                next_state = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

// File: src/bus_route.sv
module bus_route
    import mem_pkg::*;
(
    input  arb_state_t    grant,
    input  mem_bus_req_t  req1,
    input  mem_bus_req_t  req2,
    output mem_bus_resp_t resp1,
    output mem_bus_resp_t resp2,
    output mem_bus_req_t  bus_req,
    input  mem_bus_resp_t bus_resp
);

    // request side, the owner drives the shared bus
    always_comb begin
        case (grant)
            ARB_CACHE1: begin
                bus_req = req1;
            end
            ARB_CACHE2: begin
                bus_req = req2;
            end
            default: begin
                bus_req = '0;                               // idle bus is all zero
            end
        endcase
    end

    // response side, only the owner sees data and ready
    always_comb begin
        resp1 = '0;
        resp2 = '0;
        case (grant)
            ARB_CACHE1: begin
                resp1.mem_data  = bus_resp.mem_data;
                resp1.mem_ready = bus_resp.mem_ready;
            end
            ARB_CACHE2: begin
                resp2.mem_data  = bus_resp.mem_data;
                resp2.mem_ready = bus_resp.mem_ready;
            end
            default: begin
                resp1 = '0;                                 // nobody owns the bus
                resp2 = '0;
            end
        endcase
    end

endmodule

// File: src/latency_timer.sv
`include "mem_consts.svh"

module latency_timer
    import mem_pkg::*;
(
    input  logic clock,
    input  logic rst,
    input  logic active,
    output logic done
);

    localparam lat_count_t LAST = lat_count_t'(`MEM_LATENCY - 1);

    lat_count_t count;

    // last cycle of the access
    assign done = active && (count == LAST);

    // count cycles with a strobe on the bus, restart after the last one
    always_ff @(posedge clock) begin
        if (rst) begin
            count <= '0;
        end else if (active) begin
            if (done) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// File: src/line_memory.sv
`include "mem_consts.svh"

module line_memory
    import mem_pkg::*;
(
    input  logic          clock,
    input  logic          rst,
    input  mem_bus_req_t  bus_req,
    input  logic          done,
    output mem_bus_resp_t bus_resp
);

    localparam int IDX_BITS = $clog2(`MEM_LINES);

    line_t              lines [`MEM_LINES];
    logic [IDX_BITS-1:0] idx;

    assign idx = bus_req.mem_addr[IDX_BITS-1:0];            // upper address bits alias

    // store lands on the edge that closes the done cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `MEM_LINES; i++) begin
                lines[i] <= '0;
            end
        end else if (done && bus_req.mem_req_store) begin
            lines[idx] <= bus_req.mem_data_out;
        end
    end

    // load data shows only together with ready
    always_comb begin
        bus_resp.mem_ready = done;
        if (done && bus_req.mem_req_load) begin
            bus_resp.mem_data = lines[idx];
        end else begin
            bus_resp.mem_data = '0;
        end
    end

endmodule

// File: src/mem_consts.svh
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// one cache line is 64 bytes
`define MEM_LINE_BITS 512

// 64 bit byte address minus the 6 offset bits
`define MEM_ADDR_BITS 58

// backing store depth, indexed by the low address bits
`define MEM_LINES 16

// cycles per access of the second-level memory
`define MEM_LATENCY 3

`endif

// File: src/mem_pkg.sv
`include "mem_consts.svh"

package mem_pkg;

    typedef logic [`MEM_LINE_BITS-1:0] line_t;              // one full cache line
    typedef logic [`MEM_ADDR_BITS-1:0] line_addr_t;         // line aligned address

    // wide enough to hold MEM_LATENCY itself
    typedef logic [$clog2(`MEM_LATENCY + 1)-1:0] lat_count_t;

    // request from a cache, strobes are levels held until ready
    typedef struct packed {
        line_addr_t mem_addr;
        line_t      mem_data_out;                           // store data
        logic       mem_req_load;
        logic       mem_req_store;
    } mem_bus_req_t;

    // answer to a cache, ready is a single cycle pulse
    typedef struct packed {
        line_t mem_data;                                    // load data
        logic  mem_ready;
    } mem_bus_resp_t;

    // bus owner, one bit per cache
    typedef enum logic [1:0] {
        ARB_IDLE   = 2'b00,
        ARB_CACHE1 = 2'b01,
        ARB_CACHE2 = 2'b10
    } arb_state_t;

endpackage

// File: src/mem_subsystem_top.sv
module mem_subsystem_top
    import mem_pkg::*;
(
    input  logic          clock,
    input  logic          rst,
    input  mem_bus_req_t  req1,
    output mem_bus_resp_t resp1,
    input  mem_bus_req_t  req2,
    output mem_bus_resp_t resp2
);

    arb_state_t    grant;
    mem_bus_req_t  bus_req;
    mem_bus_resp_t bus_resp;
    logic          req1_active;
    logic          req2_active;
    logic          bus_active;                              // load or store on the bus
    logic          done;

    assign req1_active = req1.mem_req_load | req1.mem_req_store;
    assign req2_active = req2.mem_req_load | req2.mem_req_store;
    assign bus_active  = bus_req.mem_req_load | bus_req.mem_req_store;

    bus_arbiter_fsm u_bus_arbiter_fsm (
        .clock       (clock),
        .rst         (rst),
        .req1_active (req1_active),
        .req2_active (req2_active),
        .bus_ready   (bus_resp.mem_ready),
        .grant       (grant)
    );

    bus_route u_bus_route (
        .grant    (grant),
        .req1     (req1),
        .req2     (req2),
        .resp1    (resp1),
        .resp2    (resp2),
        .bus_req  (bus_req),
        .bus_resp (bus_resp)
    );

    latency_timer u_latency_timer (
        .clock  (clock),
        .rst    (rst),
        .active (bus_active),
        .done   (done)
    );

    line_memory u_line_memory (
        .clock    (clock),
        .rst      (rst),
        .bus_req  (bus_req),
        .done     (done),
        .bus_resp (bus_resp)
    );

endmodule

// File: testbench/mem_subsystem_tb.sv
`include "mem_consts.svh"

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int PERIOD        = 4;
    localparam int NUM_ROWS      = 16;
    localparam int IDX_BITS      = $clog2(`MEM_LINES);
    localparam int WATCHDOG_TIME = NUM_ROWS * (`MEM_LATENCY + 4) * 2 * PERIOD + 100;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_LOAD,
        OP_STORE
    } op_t;

    // one stimulus row, both caches plus the store data seed
    typedef struct packed {
        op_t         op1;
        line_addr_t  addr1;
        op_t         op2;
        line_addr_t  addr2;
        logic [31:0] seed;
    } row_t;

    logic          clock;
    logic          rst;
    mem_bus_req_t  req1;
    mem_bus_req_t  req2;
    mem_bus_resp_t resp1;
    mem_bus_resp_t resp2;

    row_t  rows [NUM_ROWS];
    line_t model [`MEM_LINES];                              // mirror of the line memory
    int    order_q [$];                                     // caches in order of ready
    int    errors;
    int    checks;

    mem_subsystem_top u_mem_subsystem_top (
        .clock (clock),
        .rst   (rst),
        .req1  (req1),
        .resp1 (resp1),
        .req2  (req2),
        .resp2 (resp2)
    );

    initial clock = 1'b0;
    always #(PERIOD / 2) clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // fills a whole line with words from the generator
    function automatic line_t make_line(input logic [31:0] seed);
        logic [31:0] st;
        line_t       ln;
        st = 32'd87527 ^ seed;
        ln = '0;
        for (int w = 0; w < `MEM_LINE_BITS / 32; w++) begin
            st = lcg_next(st);
            ln[w*32 +: 32] = st;
        end
        return ln;
    endfunction

    function automatic mem_bus_req_t make_req(input op_t op, input line_addr_t addr,
                                              input line_t data);
        mem_bus_req_t r;
        r = '0;
        if (op != OP_NONE) begin
            r.mem_addr = addr;
        end
        if (op == OP_STORE) begin
            r.mem_data_out = data;
        end
        r.mem_req_load  = (op == OP_LOAD);
        r.mem_req_store = (op == OP_STORE);
        return r;
    endfunction

    task automatic check_value(input string name, input line_t expected, input line_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at time %0t: %s expected %0h got %0h", $time, name,
                     expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("time %0t: %s", $time, msg);
    endtask

    task automatic fill_table();
        rows[0]  = '{OP_LOAD,  58'h3,         OP_NONE,  58'h0,         32'd0};  // zero after reset
        rows[1]  = '{OP_NONE,  58'h0,         OP_LOAD,  58'h9,         32'd0};
        rows[2]  = '{OP_STORE, 58'h5,         OP_NONE,  58'h0,         32'd1};
        rows[3]  = '{OP_LOAD,  58'h5,         OP_NONE,  58'h0,         32'd0};
        rows[4]  = '{OP_NONE,  58'h0,         OP_LOAD,  58'h6,         32'd0};  // untouched line
        rows[5]  = '{OP_NONE,  58'h0,         OP_STORE, 58'h7,         32'd2};
        rows[6]  = '{OP_LOAD,  58'h7,         OP_NONE,  58'h0,         32'd0};
        rows[7]  = '{OP_STORE, 58'h8,         OP_LOAD,  58'h8,         32'd3};  // same cycle
        rows[8]  = '{OP_LOAD,  58'h7,         OP_STORE, 58'h5,         32'd4};
        rows[9]  = '{OP_NONE,  58'h0,         OP_STORE, 58'ha,         32'd5};
        rows[10] = '{OP_NONE,  58'h0,         OP_LOAD,  58'h5,         32'd0};
        rows[11] = '{OP_NONE,  58'h0,         OP_LOAD,  58'ha,         32'd0};
        rows[12] = '{OP_NONE,  58'h0,         OP_STORE, 58'h20000000a, 32'd6};  // aliases line 10
        rows[13] = '{OP_LOAD,  58'ha,         OP_NONE,  58'h0,         32'd0};
        rows[14] = '{OP_STORE, 58'hc,         OP_STORE, 58'hc,         32'd7};
        rows[15] = '{OP_LOAD,  58'hc,         OP_NONE,  58'h0,         32'd0};  // cache 2 wrote last
    endtask

    // checks one finished access and updates the model
    task automatic complete_access(input int cache, input op_t op, input line_addr_t addr,
                                   input line_t wdata, input line_t rdata, input int cycles,
                                   input logic check_lat);
        logic [IDX_BITS-1:0] idx;
        idx = addr[IDX_BITS-1:0];
        if (check_lat) begin
            check_value($sformatf("latency of cache %0d", cache), line_t'(`MEM_LATENCY),
                        line_t'(cycles));
        end
        if (op == OP_LOAD) begin
            check_value($sformatf("resp%0d.mem_data", cache), model[idx], rdata);
        end else begin
            model[idx] = wdata;
        end
    endtask

    task automatic apply_row(input row_t row);
        logic  pend1;
        logic  pend2;
        logic  drop1;
        logic  drop2;
        int    cycles;
        line_t wdata1;
        line_t wdata2;
        wdata1 = make_line(row.seed);
        wdata2 = make_line(row.seed ^ 32'h0000_5a5a);
        pend1  = (row.op1 != OP_NONE);
        pend2  = (row.op2 != OP_NONE);
        drop1  = 1'b0;
        drop2  = 1'b0;
        cycles = 0;
        order_q.delete();
        @(posedge clock);
        #1;
        req1 = make_req(row.op1, row.addr1, wdata1);
        req2 = make_req(row.op2, row.addr2, wdata2);
        while (pend1 || pend2) begin
            @(posedge clock);
            #1;
            if (drop1) begin
                req1  = '0;                                 // served, release the strobe
                drop1 = 1'b0;
            end
            if (drop2) begin
                req2  = '0;
                drop2 = 1'b0;
            end
            cycles++;
            @(negedge clock);
            if (resp1.mem_ready && resp2.mem_ready) begin
                report_failure("both caches saw ready in the same cycle");
            end
            if (resp1.mem_ready) begin
                if (!pend1) begin
                    report_failure("cache 1 saw a ready it never asked for");
                end else begin
                    complete_access(1, row.op1, row.addr1, wdata1, resp1.mem_data, cycles, 1'b1);
                    pend1 = 1'b0;
                    drop1 = 1'b1;
                    order_q.push_back(1);
                end
            end else begin
                check_value("resp1.mem_data", '0, resp1.mem_data);  // no data without ready
            end
            if (resp2.mem_ready) begin
                if (!pend2) begin
                    report_failure("cache 2 saw a ready it never asked for");
                end else begin
                    complete_access(2, row.op2, row.addr2, wdata2, resp2.mem_data, cycles,
                                    row.op1 == OP_NONE);
                    pend2 = 1'b0;
                    drop2 = 1'b1;
                    order_q.push_back(2);
                end
            end else begin
                check_value("resp2.mem_data", '0, resp2.mem_data);
            end
        end
        @(posedge clock);
        #1;
        req1 = '0;
        req2 = '0;
        if (order_q.size() == 2 && order_q[0] != 1) begin
            report_failure("cache 2 was served before cache 1");
        end
        repeat (2) @(posedge clock);                        // let the arbiter go idle
    endtask

    initial begin
        errors = 0;
        checks = 0;
        rst    = 1'b1;
        req1   = '0;
        req2   = '0;
        for (int i = 0; i < `MEM_LINES; i++) begin
            model[i] = '0;
        end
        fill_table();
        repeat (4) @(posedge clock);
        #1;
        rst = 1'b0;
        @(negedge clock);
        check_value("resp1.mem_ready", '0, line_t'(resp1.mem_ready));
        check_value("resp2.mem_ready", '0, line_t'(resp2.mem_ready));
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(rows[r]);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // ends a run where some ready never shows up
    initial begin
        #(WATCHDOG_TIME);
        $display("a ready never arrived, run stopped at time %0t", $time);
        $display("checks %0d, errors %0d", checks, errors);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule
